// ==== design/hostConfigPkg.sv ====
`default_nettype none

package hostConfigPkg;

  //////////////////////////////////////////////////////////////////////
  // basic widths
  //////////////////////////////////////////////////////////////////////

  localparam int confWidth      = 16;
  localparam int numRegs        = 32;
  localparam int regAddrWidth   = 5;
  localparam int hostWordWidth  = 24;
  localparam int chunksPerEntry = 4;
  localparam int chunkCntWidth  = 2;

  // program entry fields
  localparam int genIdxWidth = 8;
  localparam int periodWidth = 16;
  localparam int tagWidth    = 11;
  localparam int entryWidth  = 51;

  // configuration field widths
  localparam int sfFiltsWidth  = 10;
  localparam int sfStateWidth  = 27;
  localparam int sgGensWidth   = 8;
  localparam int sgGensEnWidth = 256;
  localparam int tmUnitWidth   = 16;
  localparam int tmTimeWidth   = 48;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  // first register of each field
  localparam int sfFiltsUsedIdx   = 0;
  localparam int sfIncrementIdx   = 1;
  localparam int sfDecayIdx       = 3;
  localparam int sgGensUsedIdx    = 5;
  localparam int sgGensEnIdx      = 6;
  localparam int tmUnitLenIdx     = 22;
  localparam int tmTimeElapsedIdx = 23;
  localparam int tmSendHbIdx      = 26;
  localparam int tmResetTimeIdx   = 29;
  localparam int tsReportTagsIdx  = 30;

  // last register is spare and never stored
  localparam int spareRegIdx = numRegs - 1;
  localparam int storedRegs  = numRegs - 1;

  //////////////////////////////////////////////////////////////////////
  // reset values
  //////////////////////////////////////////////////////////////////////

  // one value per field, low register first
  localparam logic [2*confWidth-1:0] sfIncrementReset  = 32'd1;
  localparam logic [confWidth-1:0]   tmUnitLenReset    = 16'd5000;
  localparam logic [3*confWidth-1:0] tmSendHbReset     = 48'd10;
  localparam logic [confWidth-1:0]   tsReportTagsReset = 16'd1;

  localparam int regBits = numRegs * confWidth;

  // whole register file image, register 0 in the low bits
  // everything not named here resets to zero
  localparam logic [regBits-1:0] regResetVals =
    (regBits'(sfIncrementReset) << (sfIncrementIdx * confWidth)) |
    (regBits'(tmUnitLenReset) << (tmUnitLenIdx * confWidth)) |
    (regBits'(tmSendHbReset) << (tmSendHbIdx * confWidth)) |
    (regBits'(tsReportTagsReset) << (tsReportTagsIdx * confWidth));

  //////////////////////////////////////////////////////////////////////
  // host word
  //////////////////////////////////////////////////////////////////////

  // kind 0 means register write
  typedef struct packed {
    logic                    kind;
    logic [regAddrWidth-1:0] addr;
    logic [1:0]              spare;
    logic [confWidth-1:0]    data;
  } regWriteT;

  // kind 1 means one program chunk
  typedef struct packed {
    logic                 kind;
    logic [6:0]           spare;
    logic [confWidth-1:0] data;
  } streamChunkT;

  // both views share the top kind bit
  typedef union packed {
    regWriteT    regWrite;
    streamChunkT streamChunk;
  } hostWord;

endpackage

`default_nettype wire

// ==== design/hostWordDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module hostWordDecoder (
  input  logic                                    clk,
  input  logic                                    rstN,

  // host channel
  input  logic                                    hostValid,
  input  logic [hostConfigPkg::hostWordWidth-1:0] hostData,
  output logic                                    hostAck,

  // register write, always accepted
  output logic                                    regWe,
  output logic [hostConfigPkg::regAddrWidth-1:0]  regAddr,
  output logic [hostConfigPkg::confWidth-1:0]     regData,

  // chunk channel to the deserializer
  output logic                                    streamValid,
  output logic [hostConfigPkg::confWidth-1:0]     streamData,
  input  logic                                    streamAck
);

  ////////////////////////////////////////////////////////////////////
  // holding slot
  ////////////////////////////////////////////////////////////////////

  logic                   slotFull;
  hostConfigPkg::hostWord slotWord;
  logic                   slotDrain;
  logic                   hostTake;

  // register words leave after one cycle, chunks wait for the ack
  assign slotDrain = regWe || (streamValid && streamAck);

  // empty now or emptying on this edge
  assign hostAck  = !slotFull || slotDrain;
  assign hostTake = hostValid && hostAck;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      slotFull <= 1'b0;
    end else if (hostTake) begin
      slotFull <= 1'b1;
    end else if (slotDrain) begin
      slotFull <= 1'b0;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (hostTake) begin
      slotWord <= hostData;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // routing by kind
  ////////////////////////////////////////////////////////////////////

  // register view
  assign regWe   = slotFull && !slotWord.regWrite.kind;
  assign regAddr = slotWord.regWrite.addr;
  assign regData = slotWord.regWrite.data;

  // chunk view
  assign streamValid = slotFull && slotWord.streamChunk.kind;
  assign streamData  = slotWord.streamChunk.data;

endmodule

`default_nettype wire

// ==== design/configRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module configRegFile (
  input  logic                                    clk,
  input  logic                                    rstN,

  // write port from the decoder
  input  logic                                    regWe,
  input  logic [hostConfigPkg::regAddrWidth-1:0]  regAddr,
  input  logic [hostConfigPkg::confWidth-1:0]     regData,

  // spike filter
  output logic [hostConfigPkg::sfFiltsWidth-1:0]  sfFiltsUsed,
  output logic [hostConfigPkg::sfStateWidth-1:0]  sfIncrement,
  output logic [hostConfigPkg::sfStateWidth-1:0]  sfDecay,

  // spike generator
  output logic [hostConfigPkg::sgGensWidth-1:0]   sgGensUsed,
  output logic [hostConfigPkg::sgGensEnWidth-1:0] sgGensEn,

  // time manager
  output logic [hostConfigPkg::tmUnitWidth-1:0]   tmUnitLen,
  output logic [hostConfigPkg::tmTimeWidth-1:0]   tmTimeElapsed,
  output logic [hostConfigPkg::tmTimeWidth-1:0]   tmSendHbEvery,
  output logic                                    tmResetTime,

  // tag splitter
  output logic                                    tsReportTags
);

  ////////////////////////////////////////////////////////////////////
  // write staging
  ////////////////////////////////////////////////////////////////////

  logic                                   wrPend;
  logic [hostConfigPkg::regAddrWidth-1:0] wrAddr;
  logic [hostConfigPkg::confWidth-1:0]    wrData;

  // spare register writes are dropped here
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPend <= 1'b0;
    end else begin
      wrPend <= regWe && (regAddr != hostConfigPkg::regAddrWidth'(hostConfigPkg::spareRegIdx));
    end
  end

  always_ff @(posedge clk) begin
    if (regWe) begin
      wrAddr <= regAddr;
      wrData <= regData;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // register storage
  ////////////////////////////////////////////////////////////////////

  logic [hostConfigPkg::storedRegs-1:0][hostConfigPkg::confWidth-1:0] regs;
  logic [hostConfigPkg::storedRegs*hostConfigPkg::confWidth-1:0]      regFlat;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs <= hostConfigPkg::regResetVals[hostConfigPkg::storedRegs*hostConfigPkg::confWidth-1:0];
    end else if (wrPend) begin
      regs[wrAddr] <= wrData;
    end
  end

  // register 0 sits in the low bits
  assign regFlat = regs;

  ////////////////////////////////////////////////////////////////////
  // field slicing
  ////////////////////////////////////////////////////////////////////

  // wide fields take the low bits of their register run
  assign sfFiltsUsed   = regFlat[hostConfigPkg::sfFiltsUsedIdx*hostConfigPkg::confWidth +:
                                 hostConfigPkg::sfFiltsWidth];
  assign sfIncrement   = regFlat[hostConfigPkg::sfIncrementIdx*hostConfigPkg::confWidth +:
                                 hostConfigPkg::sfStateWidth];
  assign sfDecay       = regFlat[hostConfigPkg::sfDecayIdx*hostConfigPkg::confWidth +:
                                 hostConfigPkg::sfStateWidth];
  assign sgGensUsed    = regFlat[hostConfigPkg::sgGensUsedIdx*hostConfigPkg::confWidth +:
                                 hostConfigPkg::sgGensWidth];
  assign sgGensEn      = regFlat[hostConfigPkg::sgGensEnIdx*hostConfigPkg::confWidth +:
                                 hostConfigPkg::sgGensEnWidth];
  assign tmUnitLen     = regFlat[hostConfigPkg::tmUnitLenIdx*hostConfigPkg::confWidth +:
                                 hostConfigPkg::tmUnitWidth];
  assign tmTimeElapsed = regFlat[hostConfigPkg::tmTimeElapsedIdx*hostConfigPkg::confWidth +:
                                 hostConfigPkg::tmTimeWidth];
  assign tmSendHbEvery = regFlat[hostConfigPkg::tmSendHbIdx*hostConfigPkg::confWidth +:
                                 hostConfigPkg::tmTimeWidth];

  // single bit flags
  assign tmResetTime  = regFlat[hostConfigPkg::tmResetTimeIdx*hostConfigPkg::confWidth];
  assign tsReportTags = regFlat[hostConfigPkg::tsReportTagsIdx*hostConfigPkg::confWidth];

endmodule

`default_nettype wire

// ==== design/programDeserializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module programDeserializer (
  input  logic                                  clk,
  input  logic                                  rstN,

  // chunk channel from the decoder
  input  logic                                  streamValid,
  input  logic [hostConfigPkg::confWidth-1:0]   streamData,
  output logic                                  streamAck,

  // program entry channel
  output logic                                  entryValid,
  input  logic                                  entryAck,
  output logic [hostConfigPkg::genIdxWidth-1:0] entryGenIdx,
  output logic [hostConfigPkg::periodWidth-1:0] entryPeriod,
  output logic [hostConfigPkg::periodWidth-1:0] entryTicks,
  output logic [hostConfigPkg::tagWidth-1:0]    entryTag
);

  ////////////////////////////////////////////////////////////////////
  // chunk assembly
  ////////////////////////////////////////////////////////////////////

  logic [hostConfigPkg::chunkCntWidth-1:0]                         chunkCnt;
  logic [hostConfigPkg::chunksPerEntry*hostConfigPkg::confWidth-1:0] assembly;
  logic                                                            chunkTake;
  logic                                                            lastChunk;

  // no chunks while a finished entry waits
  assign streamAck = !entryValid;
  assign chunkTake = streamValid && streamAck;
  assign lastChunk = chunkCnt ==
                     hostConfigPkg::chunkCntWidth'(hostConfigPkg::chunksPerEntry - 1);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      chunkCnt   <= '0;
      entryValid <= 1'b0;
    end else begin
      if (chunkTake) begin
        chunkCnt <= chunkCnt + 1'b1;
        if (lastChunk) begin
          entryValid <= 1'b1;
        end
      end
      if (entryValid && entryAck) begin
        entryValid <= 1'b0;
      end
    end
  end

  // new chunk enters at the top and moves down
  // so chunk 0 ends up in bits 15:0
  always_ff @(posedge clk) begin
    if (chunkTake) begin
      assembly <= {streamData,
                   assembly[hostConfigPkg::chunksPerEntry*hostConfigPkg::confWidth-1:
                            hostConfigPkg::confWidth]};
    end
  end

  ////////////////////////////////////////////////////////////////////
  // entry fields
  ////////////////////////////////////////////////////////////////////

  // top bits above the entry are unused
  assign {entryGenIdx, entryPeriod, entryTicks, entryTag} =
    assembly[hostConfigPkg::entryWidth-1:0];

endmodule

`default_nettype wire

// ==== design/hostConfigTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module hostConfigTop (
  input  logic                                    clk,
  input  logic                                    rstN,

  // host channel
  input  logic                                    hostValid,
  input  logic [hostConfigPkg::hostWordWidth-1:0] hostData,
  output logic                                    hostAck,

  // configuration fields
  output logic [hostConfigPkg::sfFiltsWidth-1:0]  sfFiltsUsed,
  output logic [hostConfigPkg::sfStateWidth-1:0]  sfIncrement,
  output logic [hostConfigPkg::sfStateWidth-1:0]  sfDecay,
  output logic [hostConfigPkg::sgGensWidth-1:0]   sgGensUsed,
  output logic [hostConfigPkg::sgGensEnWidth-1:0] sgGensEn,
  output logic [hostConfigPkg::tmUnitWidth-1:0]   tmUnitLen,
  output logic [hostConfigPkg::tmTimeWidth-1:0]   tmTimeElapsed,
  output logic [hostConfigPkg::tmTimeWidth-1:0]   tmSendHbEvery,
  output logic                                    tmResetTime,
  output logic                                    tsReportTags,

  // program entry channel
  output logic                                    entryValid,
  input  logic                                    entryAck,
  output logic [hostConfigPkg::genIdxWidth-1:0]   entryGenIdx,
  output logic [hostConfigPkg::periodWidth-1:0]   entryPeriod,
  output logic [hostConfigPkg::periodWidth-1:0]   entryTicks,
  output logic [hostConfigPkg::tagWidth-1:0]      entryTag
);

  // decoder to register file
  logic                                   regWe;
  logic [hostConfigPkg::regAddrWidth-1:0] regAddr;
  logic [hostConfigPkg::confWidth-1:0]    regData;

  // decoder to deserializer
  logic                                   streamValid;
  logic [hostConfigPkg::confWidth-1:0]    streamData;
  logic                                   streamAck;

  hostWordDecoder u_hostWordDecoder (
    .clk         (clk),
    .rstN        (rstN),
    .hostValid   (hostValid),
    .hostData    (hostData),
    .hostAck     (hostAck),
    .regWe       (regWe),
    .regAddr     (regAddr),
    .regData     (regData),
    .streamValid (streamValid),
    .streamData  (streamData),
    .streamAck   (streamAck)
  );

  configRegFile u_configRegFile (
    .clk           (clk),
    .rstN          (rstN),
    .regWe         (regWe),
    .regAddr       (regAddr),
    .regData       (regData),
    .sfFiltsUsed   (sfFiltsUsed),
    .sfIncrement   (sfIncrement),
    .sfDecay       (sfDecay),
    .sgGensUsed    (sgGensUsed),
    .sgGensEn      (sgGensEn),
    .tmUnitLen     (tmUnitLen),
    .tmTimeElapsed (tmTimeElapsed),
    .tmSendHbEvery (tmSendHbEvery),
    .tmResetTime   (tmResetTime),
    .tsReportTags  (tsReportTags)
  );

  programDeserializer u_programDeserializer (
    .clk         (clk),
    .rstN        (rstN),
    .streamValid (streamValid),
    .streamData  (streamData),
    .streamAck   (streamAck),
    .entryValid  (entryValid),
    .entryAck    (entryAck),
    .entryGenIdx (entryGenIdx),
    .entryPeriod (entryPeriod),
    .entryTicks  (entryTicks),
    .entryTag    (entryTag)
  );

endmodule

`default_nettype wire

// ==== sim/tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
  output logic clk,
  output logic rstN
);

  localparam int halfPeriod  = 4;
  localparam int resetCycles = 16;

  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

  // release lands on a rising edge, after the flops have seen reset
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/hostConfigTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hostConfigTb;

  localparam int waitLimit = 2000;
  localparam int cw        = hostConfigPkg::confWidth;
  localparam int aw        = hostConfigPkg::regAddrWidth;

  logic                                    clk;
  logic                                    rstN;
  logic                                    hostValid;
  logic [hostConfigPkg::hostWordWidth-1:0] hostData;
  logic                                    hostAck;
  logic                                    entryValid;
  logic                                    entryAck;
  logic [hostConfigPkg::genIdxWidth-1:0]   entryGenIdx;
  logic [hostConfigPkg::periodWidth-1:0]   entryPeriod;
  logic [hostConfigPkg::periodWidth-1:0]   entryTicks;
  logic [hostConfigPkg::tagWidth-1:0]      entryTag;
  logic [hostConfigPkg::sfFiltsWidth-1:0]  sfFiltsUsed;
  logic [hostConfigPkg::sfStateWidth-1:0]  sfIncrement;
  logic [hostConfigPkg::sfStateWidth-1:0]  sfDecay;
  logic [hostConfigPkg::sgGensWidth-1:0]   sgGensUsed;
  logic [hostConfigPkg::sgGensEnWidth-1:0] sgGensEn;
  logic [hostConfigPkg::tmUnitWidth-1:0]   tmUnitLen;
  logic [hostConfigPkg::tmTimeWidth-1:0]   tmTimeElapsed;
  logic [hostConfigPkg::tmTimeWidth-1:0]   tmSendHbEvery;
  logic                                    tmResetTime;
  logic                                    tsReportTags;

  // reference model
  logic [cw-1:0]                        modelRegs [hostConfigPkg::numRegs];
  logic [hostConfigPkg::entryWidth-1:0] expEntries [$];
  logic [cw-1:0]                        pendChunks [$];

  logic [31:0] lfsrState;
  int          ackMode;
  bit          sawAckLow;
  bit          timedOut;
  int          errCount;
  int          checkCount;
  int          testErrStart;
  string       curTest;

  tbClockGen u_tbClockGen (.clk(clk), .rstN(rstN));

  hostConfigTop u_hostConfigTop (.*);

  //////////////////////////////////////////////////////////////////////
  // random bits and model
  //////////////////////////////////////////////////////////////////////

  // taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val       = {val[30:0], lfsrState[31]};
      lfsrState = {lfsrState[30:0],
                   lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
    end
    return val;
  endfunction

  task automatic resetModel();
    for (int i = 0; i < hostConfigPkg::numRegs; i++) begin
      modelRegs[i] = '0;
    end
    for (int i = 0; i < 2; i++) begin
      modelRegs[hostConfigPkg::sfIncrementIdx + i] = hostConfigPkg::sfIncrementReset[i*cw +: cw];
    end
    modelRegs[hostConfigPkg::tmUnitLenIdx] = hostConfigPkg::tmUnitLenReset;
    for (int i = 0; i < 3; i++) begin
      modelRegs[hostConfigPkg::tmSendHbIdx + i] = hostConfigPkg::tmSendHbReset[i*cw +: cw];
    end
    modelRegs[hostConfigPkg::tsReportTagsIdx] = hostConfigPkg::tsReportTagsReset;
  endtask

  // low bits of the register run, low register first
  function automatic logic [255:0] expField(input int idx, input int width);
    logic [hostConfigPkg::numRegs*cw-1:0] flat;
    logic [255:0]                         mask;
    for (int i = 0; i < hostConfigPkg::numRegs; i++) begin
      flat[i*cw +: cw] = modelRegs[i];
    end
    mask = (256'd1 << width) - 256'd1;
    return 256'(flat >> (idx * cw)) & mask;
  endfunction

  function automatic hostConfigPkg::hostWord makeRegWord(input logic [aw-1:0] addr,
                                                          input logic [cw-1:0] data);
    hostConfigPkg::hostWord w;
    w.regWrite.kind  = 1'b0;
    w.regWrite.addr  = addr;
    w.regWrite.spare = 2'b00;
    w.regWrite.data  = data;
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string what, input logic [255:0] expVal,
                            input logic [255:0] actVal);
    checkCount++;
    assert (actVal === expVal) else begin
      errCount++;
      $display("error %s %s: expected %0h, actual %0h", curTest, what, expVal, actVal);
    end
  endtask

  task automatic checkTrue(input bit cond, input string msg);
    checkCount++;
    assert (cond) else begin
      errCount++;
      $display("%s: %s", curTest, msg);
    end
  endtask

  task automatic checkField(input int idx, input int width, input logic [255:0] actVal);
    checkValue($sformatf("field at register %0d", idx), expField(idx, width), actVal);
  endtask

  task automatic checkFields();
    checkField(hostConfigPkg::sfFiltsUsedIdx, hostConfigPkg::sfFiltsWidth, 256'(sfFiltsUsed));
    checkField(hostConfigPkg::sfIncrementIdx, hostConfigPkg::sfStateWidth, 256'(sfIncrement));
    checkField(hostConfigPkg::sfDecayIdx, hostConfigPkg::sfStateWidth, 256'(sfDecay));
    checkField(hostConfigPkg::sgGensUsedIdx, hostConfigPkg::sgGensWidth, 256'(sgGensUsed));
    checkField(hostConfigPkg::sgGensEnIdx, hostConfigPkg::sgGensEnWidth, 256'(sgGensEn));
    checkField(hostConfigPkg::tmUnitLenIdx, hostConfigPkg::tmUnitWidth, 256'(tmUnitLen));
    checkField(hostConfigPkg::tmTimeElapsedIdx, hostConfigPkg::tmTimeWidth, 256'(tmTimeElapsed));
    checkField(hostConfigPkg::tmSendHbIdx, hostConfigPkg::tmTimeWidth, 256'(tmSendHbEvery));
    checkField(hostConfigPkg::tmResetTimeIdx, 1, 256'(tmResetTime));
    checkField(hostConfigPkg::tsReportTagsIdx, 1, 256'(tsReportTags));
  endtask

  task automatic takeEntry();
    logic [hostConfigPkg::entryWidth-1:0] expVal;
    checkTrue(expEntries.size() != 0, "an entry was offered when none was expected");
    if (expEntries.size() != 0) begin
      expVal = expEntries.pop_front();
      checkValue("entry", 256'(expVal),
                 256'({entryGenIdx, entryPeriod, entryTicks, entryTag}));
    end
  endtask

  task automatic reportTimeout(input string msg);
    $display("timeout in %s: %s", curTest, msg);
    timedOut = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // channel driving
  //////////////////////////////////////////////////////////////////////

  // one cycle, ending on the falling edge
  task automatic tick();
    @(negedge clk);
    case (ackMode)
      0:       entryAck = 1'b0;
      1:       entryAck = 1'b1;
      default: entryAck = (randBits(10) < 32'd307);
    endcase
    if (!hostAck) begin
      sawAckLow = 1'b1;
    end
    // both high now means a transfer on the coming rising edge
    if (entryValid && entryAck) begin
      takeEntry();
    end
  endtask

  task automatic sendWord(input logic [hostConfigPkg::hostWordWidth-1:0] word);
    int waitCnt;
    if (timedOut) begin
      return;
    end
    hostValid = 1'b1;
    hostData  = word;
    waitCnt   = 0;
    while (!hostAck && waitCnt < waitLimit) begin
      tick();
      waitCnt++;
    end
    if (!hostAck) begin
      reportTimeout("the host word was never acknowledged");
    end else begin
      tick();
    end
    hostValid = 1'b0;
  endtask

  task automatic sendReg(input logic [aw-1:0] addr, input logic [cw-1:0] data);
    sendWord(makeRegWord(addr, data));
    // spare register keeps nothing
    if (!timedOut && addr != aw'(hostConfigPkg::numRegs - 1)) begin
      modelRegs[addr] = data;
    end
  endtask

  task automatic sendChunk(input logic [cw-1:0] data);
    hostConfigPkg::hostWord w;
    logic [hostConfigPkg::chunksPerEntry*cw-1:0] quad;
    w.streamChunk.kind  = 1'b1;
    w.streamChunk.spare = 7'd0;
    w.streamChunk.data  = data;
    sendWord(w);
    if (!timedOut) begin
      pendChunks.push_back(data);
    end
    // chunk 0 lands in the low bits
    if (pendChunks.size() == hostConfigPkg::chunksPerEntry) begin
      quad = {pendChunks[3], pendChunks[2], pendChunks[1], pendChunks[0]};
      expEntries.push_back(quad[hostConfigPkg::entryWidth-1:0]);
      pendChunks.delete();
    end
  endtask

  task automatic sendEntries(input int n);
    for (int i = 0; i < n * hostConfigPkg::chunksPerEntry; i++) begin
      sendChunk(cw'(randBits(cw)));
    end
  endtask

  task automatic drainEntries();
    int waitCnt;
    waitCnt = 0;
    while (expEntries.size() != 0 && waitCnt < waitLimit) begin
      tick();
      waitCnt++;
    end
    if (expEntries.size() != 0) begin
      reportTimeout("expected entries never came out");
    end
  endtask

  task automatic startTest(input string name);
    curTest      = name;
    testErrStart = errCount;
  endtask

  task automatic finishTest();
    $display("%s finished with %0d errors", curTest, errCount - testErrStart);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int            waitCnt;
    logic [aw-1:0] addrVal;
    logic [cw-1:0] dataVal;
    hostValid  = 1'b0;
    hostData   = '0;
    entryAck   = 1'b0;
    lfsrState  = 32'hf026_3ed4;
    ackMode    = 0;
    sawAckLow  = 1'b0;
    timedOut   = 1'b0;
    errCount   = 0;
    checkCount = 0;
    resetModel();

    startTest("resetValues");
    waitCnt = 0;
    while (rstN !== 1'b1 && waitCnt < 100) begin
      tick();
      waitCnt++;
    end
    if (rstN !== 1'b1) begin
      reportTimeout("reset was never released");
    end
    tick();
    checkFields();
    checkValue("entryValid", 256'(0), 256'(entryValid));
    checkValue("hostAck", 256'(1), 256'(hostAck));
    finishTest();

    startTest("randomRegWrites");
    ackMode = 1;
    for (int i = 0; i < 200 && !timedOut; i++) begin
      addrVal = aw'(randBits(aw));
      dataVal = cw'(randBits(cw));
      sendReg(addrVal, dataVal);
      // field follows two edges after the transfer
      tick();
      tick();
      checkFields();
    end
    finishTest();

    startTest("programEntries");
    ackMode = 1;
    sendEntries(40);
    drainEntries();
    finishTest();

    startTest("backPressure");
    ackMode   = 2;
    sawAckLow = 1'b0;
    sendEntries(40);
    drainEntries();
    checkTrue(sawAckLow, "hostAck never went low while entries were held back");
    finishTest();

    startTest("interleavedOrder");
    // park one entry, then a chunk that cannot move on
    ackMode = 0;
    sendEntries(1);
    sendChunk(cw'(randBits(cw)));
    dataVal   = ~modelRegs[hostConfigPkg::tmUnitLenIdx];
    addrVal   = aw'(hostConfigPkg::tmUnitLenIdx);
    hostValid = 1'b1;
    hostData  = makeRegWord(addrVal, dataVal);
    repeat (8) tick();
    checkTrue(!hostAck, "a register write passed a blocked chunk");
    checkFields();
    ackMode = 2;
    sendReg(addrVal, dataVal);
    for (int i = 0; i < 150 && !timedOut; i++) begin
      if (randBits(1) == 32'd1) begin
        addrVal = aw'(randBits(aw));
        dataVal = cw'(randBits(cw));
        sendReg(addrVal, dataVal);
      end else begin
        sendChunk(cw'(randBits(cw)));
      end
    end
    // complete the last partial entry
    while (pendChunks.size() != 0 && !timedOut) begin
      sendChunk(cw'(randBits(cw)));
    end
    drainEntries();
    tick();
    tick();
    checkFields();
    finishTest();

    $display("tests 5, checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0 && !timedOut) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/hostConfigPkg.sv
design/hostWordDecoder.sv
design/configRegFile.sv
design/programDeserializer.sv
design/hostConfigTop.sv
sim/tbClockGen.sv
sim/hostConfigTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module hostConfigTb -Mdir obj_dir -f project.f

simOut=$(./obj_dir/VhostConfigTb)
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx 'Test passed'; then
  exit 0
fi
exit 1
